// File: Bender.yml
package:
  name: ciaBusInterface

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ciaBusPkg.sv
      - hdl/eClockGen.sv
      - hdl/ciaAddressDecoder.sv
      - hdl/ciaChannel.sv
      - hdl/ciaAckMerge.sv
      - hdl/ciaBusInterface.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/ciaBusModel.sv
      - verification/ciaBusInterface_tb.sv

// File: ciaBusInterface.f
+incdir+hdl
hdl/ciaBusPkg.sv
hdl/eClockGen.sv
hdl/ciaAddressDecoder.sv
hdl/ciaChannel.sv
hdl/ciaAckMerge.sv
hdl/ciaBusInterface.sv
verification/ciaBusModel.sv
verification/ciaBusInterface_tb.sv

// File: hdl/ciaAckMerge.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module ciaAckMerge (
    input  logic                  CLK28_IN,
    input  logic                  rstN,
    input  logic [`CIA_COUNT-1:0] chanAck,
    output logic                  cycleAck
);

    //////////////////////////////
    // CPU acknowledge
    //////////////////////////////

    // When both chips are selected, their acknowledges arrive on the same
    // cycle. The OR then gives the CPU a single pulse for the access.
    // Each channel acknowledge is one cycle long, and so is the merged one.

    // The OR goes through one more register before it reaches the CPU.
    // The CPU therefore sees the acknowledge two clocks after the last
    // phase of the E period.
    // The asynchronous reset holds the acknowledge low for the whole reset,
    // so a CPU coming out of reset never sees a bus cycle end by mistake.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            cycleAck <= 1'b0;
        end else begin
            cycleAck <= |chanAck;
        end
    end

    // The CPU drops its address strobe once it sees this pulse.
    // By the next open point the decoder no longer raises a request.

endmodule

// File: hdl/ciaAddressDecoder.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module ciaAddressDecoder (
    input  logic                  CLK28_IN,
    input  logic                  rstN,
    input  ciaBusPkg::ciaAddr_t   address,
    input  logic                  addrStrobe,
    output logic [`CIA_COUNT-1:0] ciaRequest,
    output logic [3:0]            regSelect
);

    // The decode is purely combinational.
    // CLK28_IN and rstN are here so that every block wires up the same way.
    // Neither one reaches the logic below.

    //////////////////////////////
    // Region match
    //////////////////////////////

    // CIA space is the whole BF page.
    // Odd and even byte accesses are not told apart here, since the
    // data path handles which half of the bus each chip drives.
    logic regionHit;

    assign regionHit = (address.cia.region == `CIA_REGION);

    //////////////////////////////
    // Chip requests
    //////////////////////////////

    // Each CIA has its own active-low enable bit in the address.
    // A12 belongs to CIA 0 and A13 to CIA 1.
    // Both bits low selects both chips at once. That is legal, and the
    // channels then run in parallel.
    // A request is only raised while the CPU holds its address strobe, so
    // a stale address between cycles cannot start a CIA access.
    always_comb begin
        for (int i = 0; i < `CIA_COUNT; i++) begin
            ciaRequest[i] = addrStrobe && regionHit && !address.cia.chipEnN[i];
        end
    end

    //////////////////////////////
    // Register select
    //////////////////////////////

    // A11 to A8 choose one of the 16 registers inside a CIA.
    // Both chips share these pins, and only a selected chip acts on them.
    // They are passed on without gating, so they settle well before the
    // select window opens.
    assign regSelect = address.cia.regNum;

    // A23 to A16 were tested above.
    // A7 to A1, and A15 and A14, play no part in CIA selection.

endmodule

// File: hdl/ciaBusInterface.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module ciaBusInterface (
    input  logic                  CLK28_IN,
    input  logic                  rstN,
    input  ciaBusPkg::ciaAddr_t   address,
    input  logic                  addrStrobe,
    output logic                  eClk,
    output logic [`CIA_COUNT-1:0] ciaSelN,
    output logic [3:0]            regSelect,
    output logic                  cycleAck
);

    import ciaBusPkg::*;

    // Shared timebase, visible on the top level only as E.
    ePhase_t ePhase;
    logic    vmaOpen;
    logic    vmaClose;
    logic    ackPoint;

    // Decoder to channel requests, and channel to merger acknowledges.
    logic [`CIA_COUNT-1:0] ciaRequest;
    logic [`CIA_COUNT-1:0] chanAck;

    //////////////////////////////
    // Timebase and decode
    //////////////////////////////

    eClockGen eClockGen_inst (
        .CLK28_IN (CLK28_IN),
        .rstN     (rstN),
        .ePhase   (ePhase),
        .eClk     (eClk),
        .vmaOpen  (vmaOpen),
        .vmaClose (vmaClose),
        .ackPoint (ackPoint)
    );

    ciaAddressDecoder ciaAddressDecoder_inst (
        .CLK28_IN   (CLK28_IN),
        .rstN       (rstN),
        .address    (address),
        .addrStrobe (addrStrobe),
        .ciaRequest (ciaRequest),
        .regSelect  (regSelect)
    );

    //////////////////////////////
    // Channels and acknowledge
    //////////////////////////////

    // One sequencer for each CIA. All of them share the phase strobes.
    for (genvar i = 0; i < `CIA_COUNT; i++) begin : gen_channel
        ciaChannel ciaChannel_inst (
            .CLK28_IN   (CLK28_IN),
            .rstN       (rstN),
            .ciaRequest (ciaRequest[i]),
            .vmaOpen    (vmaOpen),
            .vmaClose   (vmaClose),
            .ackPoint   (ackPoint),
            .ciaSelN    (ciaSelN[i]),
            .chanAck    (chanAck[i])
        );
    end

    ciaAckMerge ciaAckMerge_inst (
        .CLK28_IN (CLK28_IN),
        .rstN     (rstN),
        .chanAck  (chanAck),
        .cycleAck (cycleAck)
    );

endmodule

// File: hdl/ciaBusPkg.sv
package ciaBusPkg;

    //////////////////////////////
    // CPU address views
    //////////////////////////////

    // Field layout of CPU address bits 23 to 1 as the CIA decode sees them.
    // The fields are listed from the most significant bit down.
    typedef struct packed {
        // A23 to A16. CIA space is the BF page.
        logic [7:0] region;
        // A15 and A14 take no part in the CIA decode.
        logic [1:0] upperBits;
        // A13 and A12, both active low. Bit 1 enables CIA 1 and bit 0 enables CIA 0.
        logic [1:0] chipEnN;
        // A11 to A8 go straight to the RS pins of both chips.
        logic [3:0] regNum;
        // A7 to A1 are left to the data path.
        logic [6:0] lowBits;
    } ciaFields_t;

    // The address word is read both as a flat address and as CIA fields.
    // Both views cover the same 23 bits.
    typedef union packed {
        logic [22:0] raw;
        ciaFields_t  cia;
    } ciaAddr_t;

    //////////////////////////////
    // E clock timebase
    //////////////////////////////

    // Position within one E period.
    // Only the values 0 to 39 occur, so six bits are enough.
    typedef logic [5:0] ePhase_t;

endpackage

// File: hdl/ciaBus_macros.svh
`ifndef CIA_BUS_MACROS_SVH
`define CIA_BUS_MACROS_SVH

// One E period is 40 cycles of the 28 MHz clock.
// E is low for 24 cycles and high for 16.
`define CIA_E_PERIOD 40

// Phase at which E is set high.
`define CIA_E_RISE 24

// The select window closes here, early in the next E period.
`define CIA_VMA_CLEAR 3

// A pending request opens the select window here, ahead of the E rise.
`define CIA_VMA_SET 17

// Number of CIA chips on the bus.
`define CIA_COUNT 2

// A23 to A16 value that marks CIA space.
`define CIA_REGION 8'hBF

`endif

// File: hdl/ciaChannel.sv
`timescale 1ns/1ps

module ciaChannel (
    input  logic CLK28_IN,
    input  logic rstN,
    input  logic ciaRequest,
    input  logic vmaOpen,
    input  logic vmaClose,
    input  logic ackPoint,
    output logic ciaSelN,
    output logic chanAck
);

    // One of these runs for each CIA chip.
    // All copies share the phase strobes from the E clock generator.
    // Chips selected together therefore open, acknowledge and close on the
    // same cycles.

    //////////////////////////////
    // Select window
    //////////////////////////////

    // Set while this chip owns a select window.
    logic active;

    // The window opens at the VMA point when a request is pending.
    // The request is only sampled there. If it drops later, the window
    // still stays open, since the chip has already seen the cycle start
    // and must finish it on the E edge.
    // The window closes at the clear point in the following period.
    // By then the acknowledge has already gone out.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            active <= 1'b0;
        end else if (vmaClose) begin
            active <= 1'b0;
        end else if (vmaOpen && ciaRequest) begin
            active <= 1'b1;
        end
    end

    // The chip select is active low and follows the window flag.
    // It goes low one cycle after the open point and high again one cycle
    // after the clear point.
    assign ciaSelN = ~active;

    //////////////////////////////
    // Acknowledge
    //////////////////////////////

    // The CIA finishes its transfer as E falls.
    // The acknowledge is registered from the last phase before that edge,
    // so it appears in the first cycle of the new period.
    // A window runs from phase 17 to phase 3 of the next period, so it
    // holds exactly one last phase and gives exactly one acknowledge.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            chanAck <= 1'b0;
        end else begin
            chanAck <= ackPoint && active;
        end
    end

    // An idle channel does nothing until the next open point.
    // A CPU that keeps its strobe up is simply picked up there.

endmodule

// File: hdl/eClockGen.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module eClockGen (
    input  logic              CLK28_IN,
    input  logic              rstN,
    output ciaBusPkg::ePhase_t ePhase,
    output logic              eClk,
    output logic              vmaOpen,
    output logic              vmaClose,
    output logic              ackPoint
);

    import ciaBusPkg::*;

    // Last phase of the period. The counter wraps to 0 after it.
    localparam ePhase_t LAST_PHASE = ePhase_t'(`CIA_E_PERIOD - 1);

    //////////////////////////////
    // Phase counter
    //////////////////////////////

    // The counter runs from the 28 MHz clock and not from the CPU clock.
    // A video device that takes over the CPU clock therefore cannot stretch E.
    // Each period holds 40 steps.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            ePhase <= '0;
        end else if (ePhase == LAST_PHASE) begin
            ePhase <= '0;
        end else begin
            ePhase <= ePhase + ePhase_t'(1);
        end
    end

    //////////////////////////////
    // E clock
    //////////////////////////////

    // E is a register, so it has no decode glitches.
    // It is cleared at the start of the period and set at the rise phase.
    // Because of the register it changes one clock after those phases.
    // That gives 24 low cycles followed by 16 high cycles.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            eClk <= 1'b0;
        end else if (ePhase == '0) begin
            eClk <= 1'b0;
        end else if (ePhase == ePhase_t'(`CIA_E_RISE)) begin
            eClk <= 1'b1;
        end
    end

    //////////////////////////////
    // Phase strobes
    //////////////////////////////

    // Each strobe is high for exactly one cycle per period.
    // All channels read the same strobes, so they stay in lockstep with E.

    // A request seen here takes the select window.
    assign vmaOpen  = (ePhase == ePhase_t'(`CIA_VMA_SET));

    // The window closes here, after the E cycle has finished.
    assign vmaClose = (ePhase == ePhase_t'(`CIA_VMA_CLEAR));

    // Last cycle before E falls. The acknowledge is timed from this point.
    assign ackPoint = (ePhase == LAST_PHASE);

endmodule

// File: verification/ciaBusInterface_tb.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module ciaBusInterface_tb;

    import ciaBusPkg::*;

    localparam int RESET_CYCLES      = 5;
    localparam int ACCESS_COUNT      = 200;
    localparam int CYCLES_PER_ACCESS = 3 * `CIA_E_PERIOD;
    localparam int TIMEOUT_CYCLES    = RESET_CYCLES + ACCESS_COUNT * CYCLES_PER_ACCESS + 100;

    logic                  CLK28_IN;
    logic                  rstN;
    ciaAddr_t              address;
    logic                  addrStrobe;
    logic                  eClk;
    logic [`CIA_COUNT-1:0] ciaSelN;
    logic [3:0]            regSelect;
    logic                  cycleAck;

    // Outputs of the reference model.
    logic                  expEClk;
    logic [`CIA_COUNT-1:0] expSelN;
    logic [3:0]            expRegSelect;
    logic                  expCycleAck;

    // State of the E period measurement.
    logic prevEClk;
    int   runLength;
    int   edgeCount;
    int   cycleCount;

    ciaBusInterface ciaBusInterface_inst (
        .CLK28_IN   (CLK28_IN),
        .rstN       (rstN),
        .address    (address),
        .addrStrobe (addrStrobe),
        .eClk       (eClk),
        .ciaSelN    (ciaSelN),
        .regSelect  (regSelect),
        .cycleAck   (cycleAck)
    );

    ciaBusModel ciaBusModel_inst (
        .CLK28_IN     (CLK28_IN),
        .rstN         (rstN),
        .address      (address),
        .addrStrobe   (addrStrobe),
        .expEClk      (expEClk),
        .expSelN      (expSelN),
        .expRegSelect (expRegSelect),
        .expCycleAck  (expCycleAck)
    );

    // 4 ns period.
    always #2 CLK28_IN = ~CLK28_IN;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    //////////////////////////////
    // Per-cycle compare
    //////////////////////////////

    // Outputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge CLK28_IN) begin
        if (!rstN) begin
            checkValue("ciaSelN in reset", {`CIA_COUNT{1'b1}}, ciaSelN);
            checkValue("cycleAck in reset", 1'b0, cycleAck);
            checkValue("eClk in reset", 1'b0, eClk);
        end
        checkValue("eClk", expEClk, eClk);
        checkValue("ciaSelN", expSelN, ciaSelN);
        checkValue("regSelect", expRegSelect, regSelect);
        checkValue("cycleAck", expCycleAck, cycleAck);
        // The first run after reset is cut short, so only later runs are measured.
        if (rstN) begin
            if (eClk !== prevEClk) begin
                if (edgeCount > 0) begin
                    checkValue(prevEClk ? "eClk high time" : "eClk low time",
                               prevEClk ? `CIA_E_PERIOD - `CIA_E_RISE : `CIA_E_RISE, runLength);
                end
                edgeCount++;
                runLength = 1;
            end else begin
                runLength++;
            end
            prevEClk = eClk;
        end
    end

    always @(posedge CLK28_IN) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run hung waiting for an acknowledge after %0d cycles",
                     cycleCount);
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation timeout.");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One CPU bus cycle. Inputs change 1 ns after a rising edge.
    task automatic runAccess();
        ciaAddr_t   nextAddr;
        logic [7:0] region;
        logic       ackExpected;
        int         holdCycles;
        int         ackCount;
        ackCount = 0;
        repeat ($urandom_range(3, 1)) begin
            @(posedge CLK28_IN);
            #1;
        end
        // Half of the accesses land in the BF page, the rest anywhere else.
        if ($urandom_range(1, 0) == 1) begin
            region = `CIA_REGION;
        end else begin
            region = 8'($urandom_range(254, 0));
            if (region >= `CIA_REGION) begin
                region++;
            end
        end
        nextAddr.raw = {region, 15'($urandom)};
        ackExpected  = (region == `CIA_REGION) && (nextAddr.raw[12:11] != 2'b11);
        address      = nextAddr;
        addrStrobe   = 1'b1;
        if (ackExpected) begin
            // The CPU holds the strobe until the acknowledge shows up.
            do begin
                @(posedge CLK28_IN);
                #1;
            end while (cycleAck !== 1'b1);
            // The window is still open here, and the enable bits map straight to selects.
            checkValue("ciaSelN at acknowledge", nextAddr.raw[12:11], ciaSelN);
            checkValue("regSelect at acknowledge", nextAddr.raw[10:7], regSelect);
        end else begin
            holdCycles = $urandom_range(60, 5);
            repeat (holdCycles) begin
                @(posedge CLK28_IN);
                #1;
                if (cycleAck === 1'b1) begin
                    ackCount++;
                end
            end
            checkValue("cycleAck count for non-CIA access", 0, ackCount);
        end
        addrStrobe = 1'b0;
    endtask

    initial begin
        CLK28_IN    = 1'b0;
        rstN        = 1'b0;
        address.raw = '0;
        addrStrobe  = 1'b0;
        prevEClk    = 1'b0;
        runLength   = 0;
        edgeCount   = 0;
        cycleCount  = 0;
        void'($urandom(32'he2e4));
        repeat (RESET_CYCLES) @(posedge CLK28_IN);
        #1;
        rstN = 1'b1;
        for (int n = 0; n < ACCESS_COUNT; n++) begin
            runAccess();
        end
        // A few more cycles let the last window close under the compare.
        repeat (2 * `CIA_E_PERIOD) @(posedge CLK28_IN);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/ciaBusModel.sv
`timescale 1ns/1ps

`include "ciaBus_macros.svh"

module ciaBusModel (
    input  logic                  CLK28_IN,
    input  logic                  rstN,
    input  ciaBusPkg::ciaAddr_t   address,
    input  logic                  addrStrobe,
    output logic                  expEClk,
    output logic [`CIA_COUNT-1:0] expSelN,
    output logic [3:0]            expRegSelect,
    output logic                  expCycleAck
);

    import ciaBusPkg::*;

    // Reference timebase, kept apart from the one in the DUT.
    ePhase_t phase;

    // Chips that the current bus cycle asks for.
    logic [`CIA_COUNT-1:0] wantChip;

    // Chips that own the select window at the moment.
    logic [`CIA_COUNT-1:0] window;

    // First stage of the two-clock acknowledge delay.
    logic ackStage;
    logic inCiaSpace;

    //////////////////////////////
    // Address rules
    //////////////////////////////

    // The fields are taken by bit position in the flat word, where bit 0 holds A1.
    // A23 to A16 sit in bits 22 to 15.
    assign inCiaSpace = (address.raw[22:15] == `CIA_REGION);

    // A11 to A8 sit in bits 10 to 7.
    assign expRegSelect = address.raw[10:7];

    // A12 is bit 11 and A13 is bit 12, one active-low enable per chip.
    always_comb begin
        for (int c = 0; c < `CIA_COUNT; c++) begin
            wantChip[c] = addrStrobe && inCiaSpace && (address.raw[11 + c] == 1'b0);
        end
    end

    //////////////////////////////
    // Expected timing
    //////////////////////////////

    // One step per clock through the 40-step period.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else begin
            phase <= (phase == ePhase_t'(`CIA_E_PERIOD - 1)) ? '0 : phase + ePhase_t'(1);
        end
    end

    // E follows the phase by one clock.
    // It is high after the phases from the rise point up to the wrap.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            expEClk <= 1'b0;
        end else begin
            expEClk <= (phase >= ePhase_t'(`CIA_E_RISE));
        end
    end

    // Requests are only taken at the open point.
    // The window then runs until the clear point, whatever the strobe does.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            window <= '0;
        end else if (phase == ePhase_t'(`CIA_VMA_CLEAR)) begin
            window <= '0;
        end else if (phase == ePhase_t'(`CIA_VMA_SET)) begin
            window <= window | wantChip;
        end
    end

    assign expSelN = ~window;

    // A window holds one last phase, so it yields one acknowledge.
    // Two chips in the same window still give a single pulse.
    always_ff @(posedge CLK28_IN or negedge rstN) begin
        if (!rstN) begin
            ackStage    <= 1'b0;
            expCycleAck <= 1'b0;
        end else begin
            ackStage    <= (phase == ePhase_t'(`CIA_E_PERIOD - 1)) && (window != '0);
            expCycleAck <= ackStage;
        end
    end

endmodule
